/* keccak_core.f */
+incdir+common
common/keccak_pkg.sv
keccak_round/keccak_rc_gen.sv
keccak_round/keccak_round.sv
design/keccak_sponge_state.sv
design/keccak_top.sv
tb/keccak_sva.sv
tb/keccak_tb.sv

/* run.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module keccak_tb -o keccak_sim -f keccak_core.f \
  || { echo "build failed"; exit 1; }
out="$(./obj_dir/keccak_sim)"
echo "$out"
echo "$out" | grep -q "RESULT: PASS" && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }

/* tb/keccak_tb.sv */
`timescale 1ns/1ns
`include "keccak_defs.svh"

module keccak_tb
  import keccak_pkg::*;
();

  localparam int TMO = 400;  // cycles per wait loop

  // standard rho offsets, indexed x + 5y
  localparam int ROT [`KECCAK_LANES] = '{
     0,  1, 62, 28, 27,
    36, 44,  6, 55, 20,
     3, 10, 43, 25, 39,
    41, 45, 15, 21,  8,
    18,  2, 61, 56, 14
  };

  logic      clk;
  logic      i_rst;
  in_beat_t  i_in_beat;
  logic      i_in_is_ready;
  logic      o_in_can_receive;
  out_beat_t o_out_beat;
  logic      o_out_is_ready;
  logic      i_out_can_receive;

  integer      seed = 32'h1c143f12;
  int          errors = 0;
  int          n_pass = 0;
  int          n_fail = 0;
  logic [63:0] blk      [`KECCAK_LANES];
  logic [63:0] model_st [`KECCAK_LANES];  // expected retained state
  logic [63:0] first_out;

  keccak_top u_dut (
    .clk               (clk),
    .i_rst             (i_rst),
    .i_in_beat         (i_in_beat),
    .i_in_is_ready     (i_in_is_ready),
    .o_in_can_receive  (o_in_can_receive),
    .o_out_beat        (o_out_beat),
    .o_out_is_ready    (o_out_is_ready),
    .i_out_can_receive (i_out_can_receive)
  );

  bind keccak_top keccak_sva u_sva (
    .clk               (clk),
    .i_rst             (i_rst),
    .o_in_can_receive  (o_in_can_receive),
    .o_out_beat        (o_out_beat),
    .o_out_is_ready    (o_out_is_ready),
    .i_out_can_receive (i_out_can_receive)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  ////////////////////////////////////////////////////////////
  // reference model of keccak-f[1600]
  function automatic logic [63:0] rotl(input logic [63:0] v, input int n);
    if (n == 0) return v;
    return (v << n) | (v >> (64 - n));
  endfunction

  task automatic permute();
    logic [63:0] c [5];
    logic [63:0] b [`KECCAK_LANES];
    logic [7:0]  lfsr;
    logic [63:0] rc;
    lfsr = 8'h01;
    for (int r = 0; r < `KECCAK_ROUNDS; r++) begin
      for (int x = 0; x < 5; x++)
        c[x] = model_st[x] ^ model_st[x+5] ^ model_st[x+10] ^ model_st[x+15] ^ model_st[x+20];
      for (int i = 0; i < 25; i++)
        model_st[i] ^= c[(i + 4) % 5] ^ rotl(c[(i + 1) % 5], 1);
      // lane (x, y) goes to (y, 2x + 3y)
      for (int x = 0; x < 5; x++)
        for (int y = 0; y < 5; y++)
          b[y + 5 * ((2 * x + 3 * y) % 5)] = rotl(model_st[x + 5 * y], ROT[x + 5 * y]);
      for (int i = 0; i < 25; i++)
        model_st[i] = b[i] ^ (~b[(i / 5) * 5 + (i + 1) % 5] & b[(i / 5) * 5 + (i + 2) % 5]);
      rc = '0;
      for (int j = 0; j < 7; j++) begin
        rc[(1 << j) - 1] = lfsr[0];
        lfsr = lfsr[7] ? ((lfsr << 1) ^ 8'h71) : (lfsr << 1);
      end
      model_st[0] ^= rc;
    end
  endtask

  ////////////////////////////////////////////////////////////
  // checking helpers
  task automatic check_val(input string name, input logic [63:0] exp, input logic [63:0] got);
    assert (got === exp) else begin
      $display("FAILED at %0t ns: %s expected %h, got %h", $time, name, exp, got);
      errors++;
    end
  endtask

  task automatic abort_on_timeout(input string what);
    $display("timeout while %s, no handshake within %0d cycles", what, TMO);
    $display("RESULT: FAIL");
    $finish;
  endtask

  task automatic report_test(input string name, input int errs_before);
    if (errors == errs_before) begin
      n_pass++;
      $display("test %s: passed", name);
    end else begin
      n_fail++;
      $display("test %s: failed with %0d errors", name, errors - errs_before);
    end
  endtask

  ////////////////////////////////////////////////////////////
  // bus drivers
  task automatic send_block(input logic cont, input bit gaps);
    int k;
    int t;
    k = 0;
    t = 0;
    while (k < `KECCAK_LANES) begin
      @(posedge clk);
      i_in_is_ready <= gaps ? ($random(seed) % 3 != 0) : 1'b1;
      i_in_beat     <= '{data: blk[k], cont: cont};
      @(negedge clk);
      if (i_in_is_ready && o_in_can_receive) k++;  // transfers on the coming edge
      t++;
      if (t > TMO) abort_on_timeout("sending input lanes");
    end
    @(posedge clk);  // lane 24 transfers here
    i_in_is_ready <= 1'b0;
  endtask

  task automatic recv_block(input bit gaps);
    int k;
    int t;
    int lat;
    bit seen;
    k = 0;
    t = 0;
    lat = 0;
    seen = 1'b0;
    while (k < `KECCAK_LANES) begin
      @(negedge clk);
      t++;
      if (!seen) begin
        lat++;
        if (o_out_is_ready) begin
          seen = 1'b1;
          if (!gaps) check_val("o_out_is_ready latency", 64'(25), 64'(lat));
        end
      end
      check_val("o_in_can_receive", 64'(0), 64'(o_in_can_receive));
      if (o_out_is_ready && i_out_can_receive) begin
        if (k == 0) first_out = o_out_beat.data;
        check_val($sformatf("o_out_beat.data lane %0d", k), model_st[k], o_out_beat.data);
        check_val("o_out_beat.last", 64'(k == 24), 64'(o_out_beat.last));
        k++;
      end
      if (t > TMO) abort_on_timeout("waiting for output lanes");
      @(posedge clk);
      i_out_can_receive <= gaps ? ($random(seed) % 3 != 0) : 1'b1;
    end
    @(negedge clk);
    check_val("o_in_can_receive after lane 24", 64'(1), 64'(o_in_can_receive));
  endtask

  task automatic run_block(input logic cont, input bit rnd, input bit gaps);
    for (int k = 0; k < `KECCAK_LANES; k++) begin
      blk[k] = rnd ? {$random(seed), $random(seed)} : 64'h0;
      model_st[k] = cont ? (model_st[k] ^ blk[k]) : blk[k];
    end
    permute();
    send_block(cont, gaps);
    recv_block(gaps);
  endtask

  ////////////////////////////////////////////////////////////
  // test sequence
  initial begin
    int mark;
    i_rst             = 1'b1;
    i_in_beat         = '0;
    i_in_is_ready     = 1'b0;
    i_out_can_receive = 1'b0;
    for (int k = 0; k < `KECCAK_LANES; k++) model_st[k] = '0;
    repeat (4) @(posedge clk);
    i_rst <= 1'b0;

    mark = errors;
    run_block(1'b0, 1'b0, 1'b0);
    check_val("o_out_beat.data lane 0", 64'hF1258F7940E1DDE7, first_out);
    report_test("1 zero state", mark);
    mark = errors;
    run_block(1'b0, 1'b1, 1'b0);
    report_test("2 random start block", mark);
    mark = errors;
    run_block(1'b1, 1'b1, 1'b0);
    report_test("3 continue block", mark);
    mark = errors;
    run_block(1'b0, 1'b1, 1'b0);
    report_test("4 fixed latency", mark);
    mark = errors;
    run_block(1'b0, 1'b1, 1'b1);
    run_block(1'b1, 1'b1, 1'b1);
    report_test("5 back-pressure", mark);

    $display("tests passed %0d, tests failed %0d", n_pass, n_fail);
    if (n_fail == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

/* tb/keccak_sva.sv */
`timescale 1ns/1ns

module keccak_sva
  import keccak_pkg::*;
(
  input logic      clk,
  input logic      i_rst,
  input logic      o_in_can_receive,
  input out_beat_t o_out_beat,
  input logic      o_out_is_ready,
  input logic      i_out_can_receive
);

  ////////////////////////////////////////////////////////////
  // bus protocol

  // load and unload share one state register
  a_one_side: assert property (
    @(posedge clk) disable iff (i_rst)
    !(o_in_can_receive && o_out_is_ready)
  ) else $error("o_in_can_receive and o_out_is_ready high together");

  // a stalled output beat must not change
  a_out_hold: assert property (
    @(posedge clk) disable iff (i_rst)
    (o_out_is_ready && !i_out_can_receive) |=> (o_out_is_ready && $stable(o_out_beat))
  ) else $error("o_out_beat changed or was withdrawn while stalled");

  ////////////////////////////////////////////////////////////
  // reset values
  a_reset_vals: assert property (
    @(posedge clk)
    i_rst |=> (o_in_can_receive && !o_out_is_ready)
  ) else $error("bus outputs not in reset values after i_rst");

endmodule

/* design/keccak_top.sv */
`timescale 1ns/1ns

module keccak_top
  import keccak_pkg::*;
(
  input  logic      clk,
  input  logic      i_rst,

  // input lane bus, 25 lanes per block in x + 5y order
  input  in_beat_t  i_in_beat,
  input  logic      i_in_is_ready,
  output logic      o_in_can_receive,

  // output lane bus
  output out_beat_t o_out_beat,
  output logic      o_out_is_ready,
  input  logic      i_out_can_receive
);

  keccak_sponge_state u_sponge_state (
    .clk               (clk),
    .i_rst             (i_rst),
    .i_in_beat         (i_in_beat),
    .i_in_is_ready     (i_in_is_ready),
    .o_in_can_receive  (o_in_can_receive),
    .o_out_beat        (o_out_beat),
    .o_out_is_ready    (o_out_is_ready),
    .i_out_can_receive (i_out_can_receive)
  );

endmodule

/* design/keccak_sponge_state.sv */
`timescale 1ns/1ns
`include "keccak_defs.svh"

module keccak_sponge_state
  import keccak_pkg::*;
(
  input  logic      clk,
  input  logic      i_rst,

  input  in_beat_t  i_in_beat,
  input  logic      i_in_is_ready,
  output logic      o_in_can_receive,

  output out_beat_t o_out_beat,
  output logic      o_out_is_ready,
  input  logic      i_out_can_receive
);

  localparam logic [1:0] PH_LOAD   = 2'd0;
  localparam logic [1:0] PH_PERM   = 2'd1;
  localparam logic [1:0] PH_UNLOAD = 2'd2;

  localparam logic [`KECCAK_LANE_IDX_W-1:0] LAST_LANE  = `KECCAK_LANE_IDX_W'(`KECCAK_LANES - 1);
  localparam logic [`KECCAK_LANE_IDX_W-1:0] LAST_ROUND = `KECCAK_LANE_IDX_W'(`KECCAK_ROUNDS - 1);

  logic [1:0]                    phase_q;
  logic [`KECCAK_LANE_IDX_W-1:0] lane_idx_q;
  logic [`KECCAK_LANE_IDX_W-1:0] round_idx_q;
  logic                          cont_q;     // continue flag of the block being loaded
  state_t                        state_q;

  logic   in_xfer;
  logic   out_xfer;
  logic   blk_cont;
  lane_t  load_lane;
  logic   round_first;
  rc_t    round_rc;
  state_t round_out;

  ////////////////////////////////////////////////////////////
  // round datapath
  keccak_rc_gen u_rc_gen (
    .clk     (clk),
    .i_rst   (i_rst),
    .i_first (round_first),
    .o_rc    (round_rc)
  );

  keccak_round u_round (
    .i_state (state_q),
    .i_rc    (round_rc),
    .o_state (round_out)
  );

  assign round_first = (phase_q == PH_PERM) && (round_idx_q == '0);

  ////////////////////////////////////////////////////////////
  // lane buses
  assign o_in_can_receive = (phase_q == PH_LOAD);
  assign o_out_is_ready   = (phase_q == PH_UNLOAD);

  assign in_xfer  = i_in_is_ready & o_in_can_receive;
  assign out_xfer = o_out_is_ready & i_out_can_receive;

  // lane 0 carries the flag itself, later lanes use the latched copy
  assign blk_cont  = (lane_idx_q == '0) ? i_in_beat.cont : cont_q;
  assign load_lane = blk_cont ? (state_q.lanes[lane_idx_q] ^ i_in_beat.data)
                              : i_in_beat.data;

  assign o_out_beat = '{data: state_q.lanes[lane_idx_q], last: (lane_idx_q == LAST_LANE)};

  ////////////////////////////////////////////////////////////
  // sequencing
  always_ff @(posedge clk) begin
    if (i_rst) begin
      phase_q     <= PH_LOAD;
      lane_idx_q  <= '0;
      round_idx_q <= '0;
      cont_q      <= 1'b0;
      state_q     <= '0;
    end else begin
      case (phase_q)
        PH_LOAD: begin
          if (in_xfer) begin
            state_q.lanes[lane_idx_q] <= load_lane;
            cont_q                    <= blk_cont;
            if (lane_idx_q == LAST_LANE) begin
              phase_q     <= PH_PERM;
              lane_idx_q  <= '0;
              round_idx_q <= '0;
            end else begin
              lane_idx_q <= lane_idx_q + 1'b1;
            end
          end
        end
        PH_PERM: begin
          state_q <= round_out;   // one round per clock
          if (round_idx_q == LAST_ROUND) begin
            phase_q    <= PH_UNLOAD;
            lane_idx_q <= '0;
          end else begin
            round_idx_q <= round_idx_q + 1'b1;
          end
        end
        PH_UNLOAD: begin
          if (out_xfer) begin
            if (lane_idx_q == LAST_LANE) begin
              phase_q    <= PH_LOAD;  // state kept for a continue block
              lane_idx_q <= '0;
            end else begin
              lane_idx_q <= lane_idx_q + 1'b1;
            end
          end
        end
        default: begin
          phase_q    <= PH_LOAD;
          lane_idx_q <= '0;
        end
      endcase
    end
  end

endmodule

/* keccak_round/keccak_round.sv */
`timescale 1ns/1ns
`include "keccak_defs.svh"

module keccak_round
  import keccak_pkg::*;
(
  input  state_t i_state,
  input  rc_t    i_rc,
  output state_t o_state
);

  localparam int unsigned DIM = 5;
  localparam int unsigned LW  = `KECCAK_LANE_W;

  // rotation per lane, indexed by x + 5y
  localparam int unsigned RHO_OFS [`KECCAK_LANES] = '{
     0,  1, 62, 28, 27,
    36, 44,  6, 55, 20,
     3, 10, 43, 25, 39,
    41, 45, 15, 21,  8,
    18,  2, 61, 56, 14
  };

  function automatic int unsigned idx(int unsigned x, int unsigned y, int unsigned z);
    return LW * (DIM * y + x) + z;
  endfunction

  logic [DIM-1:0][LW-1:0]      col_par;
  logic [DIM-1:0][LW-1:0]      col_d;
  logic [`KECCAK_STATE_W-1:0]  theta_s;
  logic [`KECCAK_STATE_W-1:0]  rho_s;
  logic [`KECCAK_STATE_W-1:0]  pi_s;
  logic [`KECCAK_STATE_W-1:0]  chi_s;
  lane_t                       rc_lane;

  ////////////////////////////////////////////////////////////
  // theta
  for (genvar x = 0; x < DIM; x++) begin : g_theta_col
    assign col_par[x] = i_state.flat[idx(x, 0, 0) +: LW] ^ i_state.flat[idx(x, 1, 0) +: LW]
                      ^ i_state.flat[idx(x, 2, 0) +: LW] ^ i_state.flat[idx(x, 3, 0) +: LW]
                      ^ i_state.flat[idx(x, 4, 0) +: LW];
  end

  for (genvar x = 0; x < DIM; x++) begin : g_theta_d
    localparam int unsigned XL = (x + DIM - 1) % DIM;
    localparam int unsigned XR = (x + 1) % DIM;
    assign col_d[x] = col_par[XL] ^ {col_par[XR][LW-2:0], col_par[XR][LW-1]}; // rotl 1
  end

  for (genvar y = 0; y < DIM; y++) begin : g_theta_y
    for (genvar x = 0; x < DIM; x++) begin : g_theta_x
      assign theta_s[idx(x, y, 0) +: LW] = i_state.flat[idx(x, y, 0) +: LW] ^ col_d[x];
    end
  end

  ////////////////////////////////////////////////////////////
  // rho
  for (genvar y = 0; y < DIM; y++) begin : g_rho_y
    for (genvar x = 0; x < DIM; x++) begin : g_rho_x
      for (genvar z = 0; z < LW; z++) begin : g_rho_z
        assign rho_s[idx(x, y, (z + RHO_OFS[x + DIM * y]) % LW)] = theta_s[idx(x, y, z)];
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // pi
  for (genvar y = 0; y < DIM; y++) begin : g_pi_y
    for (genvar x = 0; x < DIM; x++) begin : g_pi_x
      assign pi_s[idx(x, y, 0) +: LW] = rho_s[idx((x + 3 * y) % DIM, x, 0) +: LW];
    end
  end

  ////////////////////////////////////////////////////////////
  // chi
  for (genvar y = 0; y < DIM; y++) begin : g_chi_y
    for (genvar x = 0; x < DIM; x++) begin : g_chi_x
      localparam int unsigned B0 = idx(x, y, 0);
      localparam int unsigned B1 = idx((x + 1) % DIM, y, 0);
      localparam int unsigned B2 = idx((x + 2) % DIM, y, 0);
      assign chi_s[B0 +: LW] = pi_s[B0 +: LW] ^ (~pi_s[B1 +: LW] & pi_s[B2 +: LW]);
    end
  end

  ////////////////////////////////////////////////////////////
  // iota puts rc bit i on lane bit 2^i - 1
  always_comb begin
    rc_lane = '0;
    for (int i = 0; i < `KECCAK_RC_W; i++) begin
      rc_lane[(1 << i) - 1] = i_rc[i];
    end
  end

  assign o_state.flat = chi_s ^ {{(`KECCAK_STATE_W - LW){1'b0}}, rc_lane};

endmodule

/* keccak_round/keccak_rc_gen.sv */
`timescale 1ns/1ns
`include "keccak_defs.svh"

module keccak_rc_gen
  import keccak_pkg::*;
(
  input  logic clk,
  input  logic i_rst,
  input  logic i_first,  // constant for round 0 comes out in this same cycle
  output rc_t  o_rc
);

  logic [7:0] lfsr_q;
  logic [7:0] lfsr_d;
  rc_t        rc_d;

  // seven lfsr steps per round give one rc bit each
  always_comb begin
    lfsr_d = lfsr_q;
    for (int i = 0; i < `KECCAK_RC_W; i++) begin
      if (i == 0 && i_first) begin
        lfsr_d = 8'h01;
      end else begin
        lfsr_d = {lfsr_d[6:0], 1'b0} ^ (8'h71 & {8{lfsr_d[7]}});
      end
      rc_d[i] = lfsr_d[0];
    end
  end

  always_ff @(posedge clk) begin
    if (i_rst) begin
      lfsr_q <= '0;
    end else begin
      lfsr_q <= lfsr_d;
    end
  end

  assign o_rc = rc_d;

endmodule

/* common/keccak_pkg.sv */
`include "keccak_defs.svh"

package keccak_pkg;

  typedef logic [`KECCAK_LANE_W-1:0] lane_t;

  // lane k sits at bits 64k +: 64, with k = x + 5y
  typedef union packed {
    logic [`KECCAK_STATE_W-1:0] flat;  // bit view for the round function
    lane_t [`KECCAK_LANES-1:0]  lanes; // lane view for load/unload
  } state_t;

  typedef logic [`KECCAK_RC_W-1:0] rc_t;

  typedef struct packed {
    lane_t data;
    logic  cont;   // only looked at on lane 0
  } in_beat_t;

  typedef struct packed {
    lane_t data;
    logic  last;   // lane 24
  } out_beat_t;

endpackage

/* common/keccak_defs.svh */
`ifndef KECCAK_DEFS_SVH
`define KECCAK_DEFS_SVH

// lane geometry of keccak-f[1600]
`define KECCAK_LANE_W 64
`define KECCAK_LANES 25
`define KECCAK_STATE_W 1600

// iteration
`define KECCAK_ROUNDS 24
`define KECCAK_RC_W 7

// wide enough for a lane index (0..24) and a round index (0..23)
`define KECCAK_LANE_IDX_W 5

`endif
